/* div_pkg.sv */
// Shared widths and enums for the signed divider
// DIV_W_DEF and FIFO_DEPTH_DEF are only defaults, div_top may override both
// Status encoding is visible on the top-level ports, keep it stable

`default_nettype none

package div_pkg;

    localparam int unsigned DIV_W_DEF      = 64;  // Operand width
    localparam int unsigned FIFO_DEPTH_DEF = 4;   // Request queue entries, power of two

    // Result status, reported together with quotient and remainder
    typedef enum logic [1:0] {
        STAT_OK       = 2'd0,
        STAT_DIV_ZERO = 2'd1,
        STAT_OVERFLOW = 2'd2
    } div_status_e;

    // Core control states
    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_RUN  = 2'd1,
        S_DONE = 2'd2
    } div_state_e;

endpackage

`default_nettype wire

/* div_req_if.sv */
// One division request between the queue and the core
// valid/ready handshake, transfer on a rising edge with both high
// valid and the operands stay stable until the transfer

`default_nettype none

interface div_req_if #(
    parameter int unsigned DIV_W = div_pkg::DIV_W_DEF
);

    logic             valid;
    logic             ready;
    logic [DIV_W-1:0] dividend;  // Two's complement
    logic [DIV_W-1:0] divisor;   // Two's complement

    modport src (
        output valid, dividend, divisor,
        input  ready
    );

    modport dst (
        input  valid, dividend, divisor,
        output ready
    );

endinterface

`default_nettype wire

/* lead_one_finder.sv */
// Combinational leading-one finder
// pos_o is the index of the highest set bit of data_i
// pos_o reads 0 when data_i is all zero, check zero_o first
// DIV_W must be at least 2

`default_nettype none

module lead_one_finder #(
    parameter int unsigned DIV_W = div_pkg::DIV_W_DEF
) (
    input  logic [DIV_W-1:0]         data_i,
    output logic [$clog2(DIV_W)-1:0] pos_o,
    output logic                     zero_o
);

    localparam int unsigned POS_W = $clog2(DIV_W);

    logic found;

    // Scan from the MSB down, the first hit wins
    always_comb begin
        found = 1'b0;
        pos_o = '0;
        for (int i = DIV_W - 1; i >= 0; i--) begin
            if (!found && data_i[i]) begin
                found = 1'b1;
                pos_o = POS_W'(i);
            end
        end
    end

    assign zero_o = ~found;

endmodule

`default_nettype wire

/* div_req_fifo.sv */
// Request queue in front of the divider core
// FIFO_DEPTH must be a power of two and at least 2
// A pushed request is at the head one cycle after its push edge
// push_ready_o is low only while the queue is full
// Push and pop may share an edge

`default_nettype none

module div_req_fifo #(
    parameter int unsigned DIV_W      = div_pkg::DIV_W_DEF,
    parameter int unsigned FIFO_DEPTH = div_pkg::FIFO_DEPTH_DEF
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             push_valid_i,
    output logic             push_ready_o,
    input  logic [DIV_W-1:0] dividend_i,
    input  logic [DIV_W-1:0] divisor_i,
    div_req_if.src           req
);

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [2*DIV_W-1:0] mem [FIFO_DEPTH];  // {dividend, divisor}
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push;
    logic               pop;

    assign push_ready_o = (count != CNT_W'(FIFO_DEPTH));
    assign push         = push_valid_i && push_ready_o;
    assign pop          = req.valid && req.ready;

    assign req.valid                   = (count != '0);
    assign {req.dividend, req.divisor} = mem[rd_ptr];  // Head entry

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= {dividend_i, divisor_i};
        end
    end

    // Pointers wrap naturally
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle, or push and pop together
            endcase
        end
    end

    // Pointer distance tracks the entry count, a full queue writes onto its head
    a_ptr_count: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        PTR_W'(wr_ptr - rd_ptr) == PTR_W'(count))
        else $error("Queue pointers disagree with the entry count");

    a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        count <= CNT_W'(FIFO_DEPTH))
        else $error("Queue count above depth");

endmodule

`default_nettype wire

/* div_core.sv */
// Iterative signed divider core, one request in flight
// Works on magnitudes, signs applied at the end (C semantics)
// Quotient truncates toward zero, remainder takes the dividend sign
// Zero divisor: quotient 0, remainder = dividend, STAT_DIV_ZERO
// Most negative / -1: most negative quotient, remainder 0, STAT_OVERFLOW
// Latency varies, at most DIV_W+2 cycles from the load edge
// Result is held in S_DONE until res_ready_i

`default_nettype none

module div_core #(
    parameter int unsigned DIV_W = div_pkg::DIV_W_DEF
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    div_req_if.dst               req,
    output logic                 res_valid_o,
    input  logic                 res_ready_i,
    output logic [DIV_W-1:0]     quotient_o,
    output logic [DIV_W-1:0]     remainder_o,
    output div_pkg::div_status_e status_o
);

    import div_pkg::*;

    localparam int unsigned      POS_W    = $clog2(DIV_W);
    localparam logic [DIV_W-1:0] MOST_NEG = {1'b1, {(DIV_W - 1){1'b0}}};

    div_state_e state_q;
    logic [POS_W:0] run_cnt;  // Cycles spent in S_RUN

    logic             q_sign;
    logic             r_sign;
    logic [DIV_W-1:0] rem_mag;   // Partial remainder
    logic [DIV_W-1:0] div_mag;
    logic [DIV_W-1:0] quo_acc;

    logic [DIV_W-1:0] in_dvd_mag;
    logic [DIV_W-1:0] in_dvs_mag;
    logic [DIV_W-1:0] lof_div_in;
    logic [POS_W-1:0] rem_pos;
    logic [POS_W-1:0] div_pos;
    logic             rem_zero;
    logic             div_zero;
    logic [POS_W-1:0] shift;
    logic [DIV_W-1:0] sll_div;
    logic [DIV_W-1:0] sll_bit;
    logic             use_full;
    logic [DIV_W-1:0] sub_val;
    logic [DIV_W-1:0] add_val;
    logic             run_done;
    logic             load;
    logic             overflow;

    assign req.ready   = (state_q == S_IDLE);
    assign load        = req.valid && req.ready;
    assign res_valid_o = (state_q == S_DONE);

    // Magnitude of the most negative value still fits as unsigned
    assign in_dvd_mag = req.dividend[DIV_W-1] ? -req.dividend : req.dividend;
    assign in_dvs_mag = req.divisor[DIV_W-1] ? -req.divisor : req.divisor;
    assign overflow   = (req.dividend == MOST_NEG) && (&req.divisor);

    // While idle the divisor finder screens the incoming divisor for zero
    assign lof_div_in = (state_q == S_IDLE) ? in_dvs_mag : div_mag;

    lead_one_finder #(
        .DIV_W(DIV_W)
    ) i_lof_rem (
        .data_i(rem_mag),
        .pos_o (rem_pos),
        .zero_o(rem_zero)
    );

    lead_one_finder #(
        .DIV_W(DIV_W)
    ) i_lof_div (
        .data_i(lof_div_in),
        .pos_o (div_pos),
        .zero_o(div_zero)
    );

    // Valid only in S_RUN with rem_mag >= div_mag, so shift never wraps there
    assign shift    = rem_pos - div_pos;
    assign sll_div  = div_mag << shift;
    assign sll_bit  = {{(DIV_W - 1){1'b0}}, 1'b1} << shift;
    assign use_full = (sll_div <= rem_mag);
    assign sub_val  = use_full ? sll_div : (sll_div >> 1);  // Half step when too large
    assign add_val  = use_full ? sll_bit : (sll_bit >> 1);
    assign run_done = rem_zero || (rem_mag < div_mag);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            run_cnt <= '0;
        end else begin
            run_cnt <= (state_q == S_RUN) ? run_cnt + 1'b1 : '0;
            case (state_q)
                S_IDLE: begin
                    if (load) begin
                        state_q <= div_zero ? S_DONE : S_RUN;
                    end
                end
                S_RUN: begin
                    if (run_done) begin
                        state_q <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (res_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        case (state_q)
            S_IDLE: begin
                if (load) begin
                    q_sign  <= req.dividend[DIV_W-1] ^ req.divisor[DIV_W-1];
                    r_sign  <= req.dividend[DIV_W-1];
                    rem_mag <= in_dvd_mag;
                    div_mag <= in_dvs_mag;
                    quo_acc <= '0;
                    if (div_zero) begin
                        status_o    <= STAT_DIV_ZERO;
                        quotient_o  <= '0;
                        remainder_o <= req.dividend;  // Skips S_RUN
                    end else if (overflow) begin
                        status_o <= STAT_OVERFLOW;
                    end else begin
                        status_o <= STAT_OK;
                    end
                end
            end
            S_RUN: begin
                if (run_done) begin
                    quotient_o  <= q_sign ? -quo_acc : quo_acc;
                    remainder_o <= r_sign ? -rem_mag : rem_mag;
                end else begin
                    rem_mag <= rem_mag - sub_val;
                    quo_acc <= quo_acc + add_val;
                end
            end
            default: ;  // Hold result in S_DONE
        endcase
    end

    a_rem_shrinks: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == S_RUN) |=> (rem_mag <= $past(rem_mag)))
        else $error("Partial remainder grew");

    // Each step drops the remainder's leading one by at least one position
    a_run_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == S_RUN) |-> (run_cnt <= (POS_W + 1)'(DIV_W)))
        else $error("Division ran longer than DIV_W+1 cycles");

    a_hold_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(quotient_o)
            && $stable(remainder_o) && $stable(status_o)))
        else $error("Result changed under back-pressure");

endmodule

`default_nettype wire

/* div_top.sv */
// Signed integer divider with a request queue
// Requests accepted on req_valid_i && req_ready_o
// Results consumed on res_valid_o && res_ready_i, in request order
// One division in flight, FIFO_DEPTH further requests queued
// FIFO_DEPTH must be a power of two and at least 2

`default_nettype none

module div_top #(
    parameter int unsigned DIV_W      = div_pkg::DIV_W_DEF,
    parameter int unsigned FIFO_DEPTH = div_pkg::FIFO_DEPTH_DEF
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,

    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  logic [DIV_W-1:0]     dividend_i,
    input  logic [DIV_W-1:0]     divisor_i,

    output logic                 res_valid_o,
    input  logic                 res_ready_i,
    output logic [DIV_W-1:0]     quotient_o,
    output logic [DIV_W-1:0]     remainder_o,
    output div_pkg::div_status_e status_o
);

    div_req_if #(.DIV_W(DIV_W)) req_if ();

    div_req_fifo #(
        .DIV_W     (DIV_W),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_div_req_fifo (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_valid_i(req_valid_i),
        .push_ready_o(req_ready_o),
        .dividend_i  (dividend_i),
        .divisor_i   (divisor_i),
        .req         (req_if)
    );

    div_core #(
        .DIV_W(DIV_W)
    ) i_div_core (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req        (req_if),
        .res_valid_o(res_valid_o),
        .res_ready_i(res_ready_i),
        .quotient_o (quotient_o),
        .remainder_o(remainder_o),
        .status_o   (status_o)
    );

endmodule

`default_nettype wire

/* tb_div.sv */
// Testbench for div_top with default parameters
// Vectors come from div_tests.txt, opened relative to the run directory
// Requests are pushed back to back so the queue fills up
// Results are drawn under random back-pressure and checked in request order
// Stops at the first mismatch

`default_nettype none

module tb_div;

    timeunit 1ns;
    timeprecision 1ps;

    import div_pkg::*;

    localparam int unsigned DIV_W      = DIV_W_DEF;
    localparam int          MAX_TESTS  = 256;
    localparam int          RST_CYCLES = 4;
    localparam int          CLK_PERIOD = 8;

    logic             clk_i;
    logic             rst_n_i;
    logic             req_valid_i;
    logic             req_ready_o;
    logic [DIV_W-1:0] dividend_i;
    logic [DIV_W-1:0] divisor_i;
    logic             res_valid_o;
    logic             res_ready_i;
    logic [DIV_W-1:0] quotient_o;
    logic [DIV_W-1:0] remainder_o;
    div_status_e      status_o;

    string            test_name [MAX_TESTS];
    logic [DIV_W-1:0] test_dvd  [MAX_TESTS];
    logic [DIV_W-1:0] test_dvs  [MAX_TESTS];
    logic [DIV_W-1:0] test_quo  [MAX_TESTS];
    logic [DIV_W-1:0] test_rem  [MAX_TESTS];
    div_status_e      test_stat [MAX_TESTS];
    int               num_tests;
    logic             tests_loaded;
    logic             saw_full;     // req_ready_o seen low by the driver
    integer           seed;

    div_top i_div_top (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_valid_i(req_valid_i),
        .req_ready_o(req_ready_o),
        .dividend_i (dividend_i),
        .divisor_i  (divisor_i),
        .res_valid_o(res_valid_o),
        .res_ready_i(res_ready_i),
        .quotient_o (quotient_o),
        .remainder_o(remainder_o),
        .status_o   (status_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_quotient(input string name, input logic [DIV_W-1:0] expected,
                                  input logic [DIV_W-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s quotient: expected %h, actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_remainder(input string name, input logic [DIV_W-1:0] expected,
                                   input logic [DIV_W-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s remainder: expected %h, actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_status(input string name, input div_status_e expected,
                                input div_status_e actual);
        if (actual !== expected) begin
            $display("FAILED %s status: expected %s, actual %s", name, expected.name(),
                     actual.name());
            stop_on_error();
        end
    endtask

    // One vector per line: name, dividend, divisor, quotient, remainder (hex), status
    task automatic load_tests();
        int               fd;
        int               n_read;
        int               stat_val;
        string            line;
        string            name;
        logic [DIV_W-1:0] dvd;
        logic [DIV_W-1:0] dvs;
        logic [DIV_W-1:0] quo;
        logic [DIV_W-1:0] rem;
        fd = $fopen("div_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open div_tests.txt");
            stop_on_error();
        end
        num_tests = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;  // Blank or comment line
            end
            n_read = $sscanf(line, "%s %h %h %h %h %d", name, dvd, dvs, quo, rem, stat_val);
            if (n_read != 6 || num_tests >= MAX_TESTS) begin
                $display("Bad line or too many vectors in div_tests.txt: %s", line);
                stop_on_error();
            end
            test_name[num_tests] = name;
            test_dvd[num_tests]  = dvd;
            test_dvs[num_tests]  = dvs;
            test_quo[num_tests]  = quo;
            test_rem[num_tests]  = rem;
            test_stat[num_tests] = div_status_e'(stat_val[1:0]);
            num_tests++;
        end
        $fclose(fd);
        if (num_tests == 0) begin
            $display("No test vectors found in div_tests.txt");
            stop_on_error();
        end
    endtask

    task automatic push_request(input int idx);
        @(negedge clk_i);
        req_valid_i = 1'b1;
        dividend_i  = test_dvd[idx];
        divisor_i   = test_dvs[idx];
        // req_ready_o comes from the registered queue count, stable until the rising edge
        while (!req_ready_o) begin
            saw_full = 1'b1;
            @(negedge clk_i);
        end
        @(posedge clk_i);  // Transfer edge
    endtask

    task automatic drive_requests();
        for (int i = 0; i < num_tests; i++) begin
            push_request(i);
        end
        @(negedge clk_i);
        req_valid_i = 1'b0;
    endtask

    task automatic collect_results();
        int idx;
        int draw;
        idx = 0;
        while (idx < num_tests) begin
            @(negedge clk_i);
            draw        = $random(seed);
            res_ready_i = draw[0];
            if (res_valid_o && res_ready_i) begin  // Consumed on the next rising edge
                check_quotient(test_name[idx], test_quo[idx], quotient_o);
                check_remainder(test_name[idx], test_rem[idx], remainder_o);
                check_status(test_name[idx], test_stat[idx], status_o);
                idx++;
            end
        end
        @(negedge clk_i);
        res_ready_i = 1'b1;
        // Every request is answered, so no further result may appear
        repeat (2 * (DIV_W + 2)) begin
            @(negedge clk_i);
            if (res_valid_o) begin
                $display("An extra result appeared after the last request was answered");
                stop_on_error();
            end
        end
    endtask

    initial begin
        seed         = 32'h8431;
        rst_n_i      = 1'b0;
        req_valid_i  = 1'b0;
        dividend_i   = '0;
        divisor_i    = '0;
        res_ready_i  = 1'b0;
        saw_full     = 1'b0;
        tests_loaded = 1'b0;
        load_tests();
        tests_loaded = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        if (!req_ready_o || res_valid_o) begin
            $display("After reset the queue is not ready or a result is already valid");
            stop_on_error();
        end
        fork
            drive_requests();
            collect_results();
        join
        if (saw_full) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("The request queue never filled, req_ready_o stayed high");
            stop_on_error();
        end
    end

    // Watchdog, worst case latency per vector with generous slack for back-pressure
    initial begin
        int timeout_cycles;
        wait (tests_loaded);
        timeout_cycles = num_tests * (DIV_W + 2) * 4 + 200;
        repeat (timeout_cycles) @(posedge clk_i);
        $display("Timeout after %0d cycles, the DUT stopped delivering results",
                 timeout_cycles);
        stop_on_error();
    end

endmodule

`default_nettype wire

/* filelist.f */
div_pkg.sv
div_req_if.sv
lead_one_finder.sv
div_req_fifo.sv
div_core.sv
div_top.sv
tb_div.sv

/* Makefile */
# Verilator build for the signed divider testbench
# The exit status of "make run" gives pass or fail

TOP := tb_div

.PHONY: all compile run clean

all: run

# Build the simulation binary from the file list
compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f filelist.f -o V$(TOP)

# Run from the project root so the test vectors are found
run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* div_tests.txt */
# Columns: name, dividend, divisor, quotient, remainder (64-bit hex), status (decimal)
# Status: 0 = STAT_OK, 1 = STAT_DIV_ZERO, 2 = STAT_OVERFLOW
pos_basic    0000000000000064 0000000000000007 000000000000000E 0000000000000002 0
pow2         0000000000001000 0000000000000010 0000000000000100 0000000000000000 0
dvd_small    0000000000000005 0000000000000009 0000000000000000 0000000000000005 0
equal        0000000000001234 0000000000001234 0000000000000001 0000000000000000 0
max_by3      7FFFFFFFFFFFFFFF 0000000000000003 2AAAAAAAAAAAAAAA 0000000000000001 0
wide_by16    123456789ABCDEF0 0000000000000010 0123456789ABCDEF 0000000000000000 0
sign_pp      0000000000000007 0000000000000002 0000000000000003 0000000000000001 0
sign_pn      0000000000000007 FFFFFFFFFFFFFFFE FFFFFFFFFFFFFFFD 0000000000000001 0
sign_np      FFFFFFFFFFFFFFF9 0000000000000002 FFFFFFFFFFFFFFFD FFFFFFFFFFFFFFFF 0
sign_nn      FFFFFFFFFFFFFFF9 FFFFFFFFFFFFFFFE 0000000000000003 FFFFFFFFFFFFFFFF 0
neg_small    FFFFFFFFFFFFFFFD 000000000000000A 0000000000000000 FFFFFFFFFFFFFFFD 0
k_by_m33     00000000000003E8 FFFFFFFFFFFFFFDF FFFFFFFFFFFFFFE2 000000000000000A 0
mk_by_33     FFFFFFFFFFFFFC18 0000000000000021 FFFFFFFFFFFFFFE2 FFFFFFFFFFFFFFF6 0
neg_wide     FEDCBA9876543210 0000000000000100 FFFEDCBA98765433 FFFFFFFFFFFFFF10 0
m1_by_m1     FFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFF 0000000000000001 0000000000000000 0
zero_dvd     0000000000000000 0000000000000005 0000000000000000 0000000000000000 0
dz_pos       000000000000002A 0000000000000000 0000000000000000 000000000000002A 1
dz_neg       FFFFFFFFFFFFFFFB 0000000000000000 0000000000000000 FFFFFFFFFFFFFFFB 1
dz_zero      0000000000000000 0000000000000000 0000000000000000 0000000000000000 1
min_by_m1    8000000000000000 FFFFFFFFFFFFFFFF 8000000000000000 0000000000000000 2
min_by_1     8000000000000000 0000000000000001 8000000000000000 0000000000000000 0
min_by_2     8000000000000000 0000000000000002 C000000000000000 0000000000000000 0
min_by_m2    8000000000000000 FFFFFFFFFFFFFFFE 4000000000000000 0000000000000000 0
max_by_min   7FFFFFFFFFFFFFFF 8000000000000000 0000000000000000 7FFFFFFFFFFFFFFF 0
min_by_min   8000000000000000 8000000000000000 0000000000000001 0000000000000000 0
